// File: hdl/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0]  sel_t;
	typedef logic [19:0] vpn_t;
	typedef logic [19:0] pfn_t;

	localparam int PAGE_BITS = 12; // 4 KB pages

	// kseg0/kseg1 and above bypass the TLB
	localparam word_t KSEG_BASE     = 32'h8000_0000;
	localparam word_t UNMAPPED_MASK = 32'h1fff_ffff; // drops the segment bits

	typedef enum logic [1:0] {
		EXC_NONE = 2'd0,
		EXC_TLBL = 2'd1, // fetch or load refill/invalid
		EXC_TLBS = 2'd2, // store refill/invalid
		EXC_TLBM = 2'd3  // store to clean page
	} exc_e;

endpackage

`default_nettype wire

// File: hdl/tlb_lookup.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_lookup #(
	parameter int TLB_ENTRIES = 8
) (
	input  wire                               clk,
	input  wire                               arst_n_i,

	input  wire                               xlt_valid_i,
	input  wire mmu_pkg::word_t               xlt_vaddr_i,
	input  wire                               xlt_store_i,
	output mmu_pkg::word_t                    xlt_paddr_o,
	output mmu_pkg::exc_e                     xlt_exc_o,

	input  wire                               tlb_wr_en_i,
	input  wire [$clog2(TLB_ENTRIES)-1:0]     tlb_wr_index_i,
	input  wire mmu_pkg::vpn_t                tlb_wr_vpn_i,
	input  wire mmu_pkg::pfn_t                tlb_wr_pfn_i,
	input  wire                               tlb_wr_valid_i,
	input  wire                               tlb_wr_dirty_i
);

	import mmu_pkg::*;

	localparam int IDX_W = $clog2(TLB_ENTRIES);

	vpn_t ent_vpn   [TLB_ENTRIES];
	pfn_t ent_pfn   [TLB_ENTRIES];
	logic ent_valid [TLB_ENTRIES];
	logic ent_dirty [TLB_ENTRIES];

	logic             hit;
	logic [IDX_W-1:0] hit_idx;
	word_t            next_paddr;
	exc_e             next_exc;

	// software refill port writes one entry per cycle
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < TLB_ENTRIES; i++) begin
				ent_vpn[i]   <= '0;
				ent_pfn[i]   <= '0;
				ent_valid[i] <= 1'b0;
				ent_dirty[i] <= 1'b0;
			end
		end else if (tlb_wr_en_i) begin
			ent_vpn[tlb_wr_index_i]   <= tlb_wr_vpn_i;
			ent_pfn[tlb_wr_index_i]   <= tlb_wr_pfn_i;
			ent_valid[tlb_wr_index_i] <= tlb_wr_valid_i;
			ent_dirty[tlb_wr_index_i] <= tlb_wr_dirty_i;
		end
	end

	// fully associative match where the lowest index wins
	always_comb begin
		hit     = 1'b0;
		hit_idx = '0;
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			if (!hit && ent_vpn[i] == xlt_vaddr_i[31:PAGE_BITS]) begin
				hit     = 1'b1;
				hit_idx = IDX_W'(i);
			end
		end
	end

	always_comb begin
		next_paddr = {ent_pfn[hit_idx], xlt_vaddr_i[PAGE_BITS-1:0]};
		next_exc   = EXC_NONE;
		if (xlt_vaddr_i >= KSEG_BASE) begin
			next_paddr = xlt_vaddr_i & UNMAPPED_MASK; // unmapped segment
		end else if (!hit || !ent_valid[hit_idx]) begin
			next_exc = xlt_store_i ? EXC_TLBS : EXC_TLBL;
		end else if (xlt_store_i && !ent_dirty[hit_idx]) begin
			next_exc = EXC_TLBM;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			xlt_exc_o <= EXC_NONE;
		end else if (xlt_valid_i) begin
			xlt_exc_o <= next_exc;
		end
	end

	always_ff @(posedge clk) begin
		if (xlt_valid_i) begin
			xlt_paddr_o <= next_paddr;
		end
	end

endmodule

`default_nettype wire

// File: hdl/access_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module access_sequencer (
	input  wire                clk,
	input  wire                arst_n_i,

	// instruction fetch
	input  wire                if_req_i,
	input  wire mmu_pkg::word_t if_addr_i,
	output logic               if_done_o,
	output mmu_pkg::word_t     if_rdata_o,
	output mmu_pkg::exc_e      if_exc_o,

	// data access
	input  wire                mem_req_i,
	input  wire                mem_we_i,
	input  wire mmu_pkg::sel_t mem_sel_i,
	input  wire mmu_pkg::word_t mem_addr_i,
	input  wire mmu_pkg::word_t mem_wdata_i,
	output logic               mem_done_o,
	output mmu_pkg::word_t     mem_rdata_o,
	output mmu_pkg::exc_e      mem_exc_o,

	// to tlb_lookup
	output logic               xlt_valid_o,
	output mmu_pkg::word_t     xlt_vaddr_o,
	output logic               xlt_store_o,
	input  wire mmu_pkg::word_t xlt_paddr_i,
	input  wire mmu_pkg::exc_e xlt_exc_i,

	// external bus
	output logic               bus_req_o,
	output logic               bus_we_o,
	output mmu_pkg::word_t     bus_addr_o,
	output mmu_pkg::word_t     bus_wdata_o,
	input  wire mmu_pkg::word_t bus_rdata_i,
	input  wire                bus_ack_i
);

	import mmu_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_XLT,
		ST_READ,
		ST_WRITE,
		ST_DONE
	} state_t;

	state_t state;
	logic   sel_mem_q;   // set when the data access owns the bus
	logic   we_q;
	logic   bus_req_q;
	exc_e   exc_q;

	sel_t   sel_q;
	word_t  bus_addr_q;
	word_t  bus_wdata_q;
	word_t  rdata_q;
	word_t  merged;

	// data side wins when both are pending
	assign xlt_valid_o = (state == ST_IDLE) && (mem_req_i || if_req_i);
	assign xlt_vaddr_o = mem_req_i ? mem_addr_i : if_addr_i;
	assign xlt_store_o = mem_req_i && mem_we_i;

	// byte merge for partial stores
	always_comb begin
		for (int b = 0; b < 4; b++) begin
			merged[8*b +: 8] = sel_q[b] ? bus_wdata_q[8*b +: 8] : bus_rdata_i[8*b +: 8];
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state     <= ST_IDLE;
			sel_mem_q <= 1'b0;
			we_q      <= 1'b0;
			bus_req_q <= 1'b0;
			exc_q     <= EXC_NONE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (xlt_valid_o) begin
						sel_mem_q <= mem_req_i;
						we_q      <= xlt_store_o;
						state     <= ST_XLT;
					end
				end
				ST_XLT: begin
					exc_q <= xlt_exc_i;
					if (xlt_exc_i != EXC_NONE) begin
						state <= ST_DONE; // a fault skips the bus
					end else if (we_q && sel_q == 4'b1111) begin
						bus_req_q <= 1'b1;
						state     <= ST_WRITE;
					end else begin
						bus_req_q <= 1'b1;
						state     <= ST_READ;
					end
				end
				ST_READ: begin
					if (bus_ack_i) begin
						bus_req_q <= 1'b0;
						state     <= we_q ? ST_WRITE : ST_DONE;
					end
				end
				ST_WRITE: begin
					if (!bus_req_q) begin
						bus_req_q <= 1'b1; // second half of read-modify-write
					end else if (bus_ack_i) begin
						bus_req_q <= 1'b0;
						state     <= ST_DONE;
					end
				end
				ST_DONE: begin
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && xlt_valid_o) begin
			sel_q       <= mem_req_i ? mem_sel_i : 4'b1111;
			bus_wdata_q <= mem_wdata_i;
		end
		if (state == ST_XLT) begin
			bus_addr_q <= xlt_paddr_i;
		end
		if (state == ST_READ && bus_ack_i) begin
			rdata_q     <= bus_rdata_i;
			bus_wdata_q <= merged;
		end
	end

	assign bus_req_o   = bus_req_q;
	assign bus_we_o    = (state == ST_WRITE);
	assign bus_addr_o  = bus_addr_q;
	assign bus_wdata_o = bus_wdata_q;

	assign if_done_o   = (state == ST_DONE) && !sel_mem_q;
	assign mem_done_o  = (state == ST_DONE) && sel_mem_q;
	assign if_rdata_o  = rdata_q;
	assign mem_rdata_o = rdata_q;
	assign if_exc_o    = exc_q;
	assign mem_exc_o   = exc_q;

endmodule

`default_nettype wire

// File: hdl/mmu_top.sv
`timescale 1ns/100ps
`default_nettype none

module mmu_top #(
	parameter int TLB_ENTRIES = 8
) (
	input  wire                           clk,
	input  wire                           arst_n_i,

	input  wire                           if_req_i,
	input  wire mmu_pkg::word_t           if_addr_i,
	output mmu_pkg::word_t                if_rdata_o,
	output mmu_pkg::exc_e                 if_exc_o,
	output logic                          if_done_o,

	input  wire                           mem_req_i,
	input  wire                           mem_we_i,
	input  wire mmu_pkg::sel_t            mem_sel_i,
	input  wire mmu_pkg::word_t           mem_addr_i,
	input  wire mmu_pkg::word_t           mem_wdata_i,
	output mmu_pkg::word_t                mem_rdata_o,
	output mmu_pkg::exc_e                 mem_exc_o,
	output logic                          mem_done_o,

	input  wire                           tlb_wr_en_i,
	input  wire [$clog2(TLB_ENTRIES)-1:0] tlb_wr_index_i,
	input  wire mmu_pkg::vpn_t            tlb_wr_vpn_i,
	input  wire mmu_pkg::pfn_t            tlb_wr_pfn_i,
	input  wire                           tlb_wr_valid_i,
	input  wire                           tlb_wr_dirty_i,

	output logic                          bus_req_o,
	output logic                          bus_we_o,
	output mmu_pkg::word_t                bus_addr_o,
	output mmu_pkg::word_t                bus_wdata_o,
	input  wire mmu_pkg::word_t           bus_rdata_i,
	input  wire                           bus_ack_i
);

	import mmu_pkg::*;

	logic  xlt_valid;
	word_t xlt_vaddr;
	logic  xlt_store;
	word_t xlt_paddr;
	exc_e  xlt_exc;

	access_sequencer access_sequencer_i (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.if_req_i    (if_req_i),
		.if_addr_i   (if_addr_i),
		.if_done_o   (if_done_o),
		.if_rdata_o  (if_rdata_o),
		.if_exc_o    (if_exc_o),
		.mem_req_i   (mem_req_i),
		.mem_we_i    (mem_we_i),
		.mem_sel_i   (mem_sel_i),
		.mem_addr_i  (mem_addr_i),
		.mem_wdata_i (mem_wdata_i),
		.mem_done_o  (mem_done_o),
		.mem_rdata_o (mem_rdata_o),
		.mem_exc_o   (mem_exc_o),
		.xlt_valid_o (xlt_valid),
		.xlt_vaddr_o (xlt_vaddr),
		.xlt_store_o (xlt_store),
		.xlt_paddr_i (xlt_paddr),
		.xlt_exc_i   (xlt_exc),
		.bus_req_o   (bus_req_o),
		.bus_we_o    (bus_we_o),
		.bus_addr_o  (bus_addr_o),
		.bus_wdata_o (bus_wdata_o),
		.bus_rdata_i (bus_rdata_i),
		.bus_ack_i   (bus_ack_i)
	);

	tlb_lookup #(
		.TLB_ENTRIES (TLB_ENTRIES)
	) tlb_lookup_i (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.xlt_valid_i    (xlt_valid),
		.xlt_vaddr_i    (xlt_vaddr),
		.xlt_store_i    (xlt_store),
		.xlt_paddr_o    (xlt_paddr),
		.xlt_exc_o      (xlt_exc),
		.tlb_wr_en_i    (tlb_wr_en_i),
		.tlb_wr_index_i (tlb_wr_index_i),
		.tlb_wr_vpn_i   (tlb_wr_vpn_i),
		.tlb_wr_pfn_i   (tlb_wr_pfn_i),
		.tlb_wr_valid_i (tlb_wr_valid_i),
		.tlb_wr_dirty_i (tlb_wr_dirty_i)
	);

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic arst_n_o
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		arst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 arst_n_o = 1'b1; // release off the edge
	end

endmodule

`default_nettype wire

// File: verif/mmu_properties.sv
`timescale 1ns/100ps
`default_nettype none

module mmu_properties (
	input wire                 clk,
	input wire                 arst_n_i,
	input wire                 bus_req_i,
	input wire                 bus_we_i,
	input wire mmu_pkg::word_t bus_addr_i,
	input wire mmu_pkg::word_t bus_wdata_i,
	input wire                 bus_ack_i,
	input wire                 if_done_i,
	input wire                 mem_done_i,
	input wire                 xlt_valid_i,
	input wire mmu_pkg::exc_e  xlt_exc_i
);

	import mmu_pkg::*;

	bus_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
		bus_req_i && !bus_ack_i |=> bus_req_i && $stable(bus_we_i) && $stable(bus_addr_i)
			&& $stable(bus_wdata_i))
		else $error("bus outputs changed while waiting for ack");

	if_done_pulse_a: assert property (@(posedge clk) disable iff (!arst_n_i)
		if_done_i |=> !if_done_i)
		else $error("if_done_o held for more than one cycle");

	mem_done_pulse_a: assert property (@(posedge clk) disable iff (!arst_n_i)
		mem_done_i |=> !mem_done_i)
		else $error("mem_done_o held for more than one cycle");

	// result cycle follows xlt_valid
	fault_no_bus_a: assert property (@(posedge clk) disable iff (!arst_n_i)
		$past(xlt_valid_i) && xlt_exc_i != EXC_NONE |=> !bus_req_i)
		else $error("bus request after a faulting translation");

endmodule

`default_nettype wire

// File: verif/mmu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mmu_tb;

	import mmu_pkg::*;

	localparam int TLB_ENTRIES = 8;
	localparam int TIMEOUT     = 100;

	wire   clk;
	wire   arst_n;
	logic  if_req;
	word_t if_addr;
	word_t if_rdata;
	exc_e  if_exc;
	logic  if_done;
	logic  mem_req;
	logic  mem_we;
	sel_t  mem_sel;
	word_t mem_addr;
	word_t mem_wdata;
	word_t mem_rdata;
	exc_e  mem_exc;
	logic  mem_done;
	logic  tlb_wr_en;
	logic [$clog2(TLB_ENTRIES)-1:0] tlb_wr_index;
	vpn_t  tlb_wr_vpn;
	pfn_t  tlb_wr_pfn;
	logic  tlb_wr_valid;
	logic  tlb_wr_dirty;
	logic  bus_req;
	logic  bus_we;
	logic  bus_ack;
	word_t bus_addr;
	word_t bus_wdata;
	word_t bus_rdata;

	word_t resp_mem [word_t];  // responder side
	word_t model_mem [word_t]; // reference side
	vpn_t  m_vpn [TLB_ENTRIES];
	pfn_t  m_pfn [TLB_ENTRIES];
	logic  m_valid [TLB_ENTRIES];
	logic  m_dirty [TLB_ENTRIES];
	word_t log_addr [$];
	word_t log_wdata [$];
	logic  log_we [$];
	time   mem_done_t;
	time   if_done_t;

	tb_clk_gen clk_gen_i (
		.clk      (clk),
		.arst_n_o (arst_n)
	);

	mmu_top #(
		.TLB_ENTRIES (TLB_ENTRIES)
	) mmu_top_i (
		.clk            (clk),
		.arst_n_i       (arst_n),
		.if_req_i       (if_req),
		.if_addr_i      (if_addr),
		.if_rdata_o     (if_rdata),
		.if_exc_o       (if_exc),
		.if_done_o      (if_done),
		.mem_req_i      (mem_req),
		.mem_we_i       (mem_we),
		.mem_sel_i      (mem_sel),
		.mem_addr_i     (mem_addr),
		.mem_wdata_i    (mem_wdata),
		.mem_rdata_o    (mem_rdata),
		.mem_exc_o      (mem_exc),
		.mem_done_o     (mem_done),
		.tlb_wr_en_i    (tlb_wr_en),
		.tlb_wr_index_i (tlb_wr_index),
		.tlb_wr_vpn_i   (tlb_wr_vpn),
		.tlb_wr_pfn_i   (tlb_wr_pfn),
		.tlb_wr_valid_i (tlb_wr_valid),
		.tlb_wr_dirty_i (tlb_wr_dirty),
		.bus_req_o      (bus_req),
		.bus_we_o       (bus_we),
		.bus_addr_o     (bus_addr),
		.bus_wdata_o    (bus_wdata),
		.bus_rdata_i    (bus_rdata),
		.bus_ack_i      (bus_ack)
	);

	bind mmu_top mmu_properties mmu_properties_i (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.bus_req_i   (bus_req_o),
		.bus_we_i    (bus_we_o),
		.bus_addr_i  (bus_addr_o),
		.bus_wdata_i (bus_wdata_o),
		.bus_ack_i   (bus_ack_i),
		.if_done_i   (if_done_o),
		.mem_done_i  (mem_done_o),
		.xlt_valid_i (xlt_valid),
		.xlt_exc_i   (xlt_exc)
	);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1);
	endtask

	// untouched words read back an address hash
	function automatic word_t fill_word(input word_t a);
		return (a * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
	endfunction

	function automatic word_t model_read(input word_t pa);
		if (model_mem.exists(pa)) return model_mem[pa];
		return fill_word(pa);
	endfunction

	function automatic exc_e model_xlt(input word_t va, input logic store, output word_t pa);
		logic hit;
		int   idx;
		hit = 1'b0;
		idx = 0;
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			if (!hit && m_vpn[i] == va[31:12]) begin
				hit = 1'b1;
				idx = i;
			end
		end
		pa = {m_pfn[idx], va[11:0]};
		if (va[31]) begin
			pa = {3'b000, va[28:0]};
			return EXC_NONE;
		end
		if (!hit || !m_valid[idx]) return store ? EXC_TLBS : EXC_TLBL;
		if (store && !m_dirty[idx]) return EXC_TLBM;
		return EXC_NONE;
	endfunction

	task automatic load_tlb(input int idx, input vpn_t v, input pfn_t p, input logic val,
			input logic d);
		@(posedge clk);
		#2;
		tlb_wr_en    = 1'b1;
		tlb_wr_index = idx[$clog2(TLB_ENTRIES)-1:0];
		tlb_wr_vpn   = v;
		tlb_wr_pfn   = p;
		tlb_wr_valid = val;
		tlb_wr_dirty = d;
		@(posedge clk);
		#2;
		tlb_wr_en    = 1'b0;
		m_vpn[idx]   = v;
		m_pfn[idx]   = p;
		m_valid[idx] = val;
		m_dirty[idx] = d;
	endtask

	// memory responder with 0 to 3 wait cycles per access
	initial begin
		int waits;
		waits = -1;
		forever begin
			@(posedge clk);
			#2;
			if (bus_ack) begin
				bus_ack = 1'b0;
			end else if (bus_req) begin
				if (waits < 0) waits = $urandom_range(0, 3);
				if (waits == 0) begin
					bus_ack   = 1'b1;
					bus_rdata = resp_mem.exists(bus_addr) ? resp_mem[bus_addr]
						: fill_word(bus_addr);
					if (bus_we) resp_mem[bus_addr] = bus_wdata;
					log_addr.push_back(bus_addr);
					log_we.push_back(bus_we);
					log_wdata.push_back(bus_wdata);
					waits = -1;
				end else begin
					waits--;
				end
			end
		end
	end

	task automatic check_read(input string who, input word_t va, input exc_e got_exc,
			input word_t got_data);
		word_t pa;
		exc_e  exp_exc;
		exp_exc = model_xlt(va, 1'b0, pa);
		assert (got_exc == exp_exc)
		else report_failure($sformatf("error: %s_exc_o got %h expected %h", who, got_exc, exp_exc));
		if (exp_exc != EXC_NONE) begin
			assert (log_addr.size() == 0)
			else report_failure("a faulting read made a bus access");
		end else begin
			assert (log_addr.size() == 1 && !log_we[0] && log_addr[0] == pa)
			else report_failure("a read did not make one bus read at the translated address");
			assert (got_data == model_read(pa))
			else report_failure($sformatf("error: %s_rdata_o got %h expected %h", who, got_data,
				model_read(pa)));
		end
	endtask

	task automatic do_fetch(input word_t va);
		int    n;
		exc_e  got_exc;
		word_t got_data;
		@(posedge clk);
		#2;
		if_req  = 1'b1;
		if_addr = va;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT) report_failure("timeout waiting for if_done_o");
		end while (!if_done);
		if_done_t = $time;
		got_exc   = if_exc;
		got_data  = if_rdata;
		@(posedge clk);
		#2;
		if_req = 1'b0;
		check_read("if", va, got_exc, got_data);
		log_addr.delete();
		log_we.delete();
		log_wdata.delete();
	endtask

	task automatic do_mem(input logic we, input sel_t sel, input word_t va, input word_t wd);
		int    n;
		exc_e  got_exc;
		exc_e  exp_exc;
		word_t got_data;
		word_t pa;
		word_t old_word;
		word_t merged;
		@(posedge clk);
		#2;
		mem_req   = 1'b1;
		mem_we    = we;
		mem_sel   = sel;
		mem_addr  = va;
		mem_wdata = wd;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT) report_failure("timeout waiting for mem_done_o");
		end while (!mem_done);
		mem_done_t = $time;
		got_exc    = mem_exc;
		got_data   = mem_rdata;
		@(posedge clk);
		#2;
		mem_req = 1'b0;
		if (!we) begin
			check_read("mem", va, got_exc, got_data);
		end else begin
			exp_exc = model_xlt(va, 1'b1, pa);
			assert (got_exc == exp_exc)
			else report_failure($sformatf("error: mem_exc_o got %h expected %h", got_exc, exp_exc));
			if (exp_exc != EXC_NONE) begin
				assert (log_addr.size() == 0)
				else report_failure("a faulting store made a bus access");
			end else begin
				old_word = model_read(pa);
				for (int b = 0; b < 4; b++) begin
					merged[8*b +: 8] = sel[b] ? wd[8*b +: 8] : old_word[8*b +: 8];
				end
				n = (sel == 4'hf) ? 1 : 2; // partial store reads first
				assert (log_addr.size() == n && log_we[n-1] && log_addr[n-1] == pa)
				else report_failure("a store did not end in one write at the translated address");
				assert (n == 1 || (!log_we[0] && log_addr[0] == pa))
				else report_failure("a partial store did not read the word first");
				assert (log_wdata[n-1] == merged)
				else report_failure($sformatf("error: bus_wdata_o got %h expected %h",
					log_wdata[n-1], merged));
				model_mem[pa] = merged;
			end
		end
		log_addr.delete();
		log_we.delete();
		log_wdata.delete();
	endtask

	function automatic word_t rand_addr(input logic mapped);
		word_t off;
		off = word_t'($urandom_range(0, 7)) << 2;
		if (mapped) return (word_t'($urandom_range(0, 11)) << 12) | off;
		return KSEG_BASE | (word_t'($urandom_range(0, 1)) << 29)
			| (word_t'($urandom_range(0, 3)) << 12) | off;
	endfunction

	task automatic rand_access(input logic mapped, input logic partial);
		int   kind;
		sel_t sel;
		kind = $urandom_range(0, 2);
		sel  = (partial && $urandom_range(0, 1) == 1) ? sel_t'($urandom) : 4'hf;
		if (kind == 0) do_fetch(rand_addr(mapped));
		else do_mem(kind == 2, sel, rand_addr(mapped), $urandom);
	endtask

	initial begin
		int n;
		if_req       = 1'b0;
		if_addr      = '0;
		mem_req      = 1'b0;
		mem_we       = 1'b0;
		mem_sel      = '0;
		mem_addr     = '0;
		mem_wdata    = '0;
		tlb_wr_en    = 1'b0;
		tlb_wr_index = '0;
		tlb_wr_vpn   = '0;
		tlb_wr_pfn   = '0;
		tlb_wr_valid = 1'b0;
		tlb_wr_dirty = 1'b0;
		bus_ack      = 1'b0;
		bus_rdata    = '0;
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			m_vpn[i]   = '0;
			m_pfn[i]   = '0;
			m_valid[i] = 1'b0;
			m_dirty[i] = 1'b0;
		end
		void'($urandom(32'hbe81));
		n = 0;
		while (!arst_n) begin
			@(posedge clk);
			n++;
			if (n > 20) report_failure("reset was never released");
		end

		repeat (40) rand_access(1'b0, 1'b0);
		// entry 6 invalid, entry 7 clean, duplicate vpns possible
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			load_tlb(i, vpn_t'($urandom_range(0, 9)), pfn_t'($urandom_range(0, 15)),
				i != 6 && $urandom_range(0, 3) != 0, i != 7 && $urandom_range(0, 1) == 1);
		end
		repeat (150) rand_access(1'b1, 1'b1);
		repeat (40) rand_access($urandom_range(0, 1) == 1, 1'b1);

		repeat (20) begin
			fork
				do_mem($urandom_range(0, 1) == 1, sel_t'($urandom), rand_addr(1'b0), $urandom);
				do_fetch(rand_addr($urandom_range(0, 1) == 1));
			join
			assert (mem_done_t < if_done_t)
			else report_failure("fetch completed before the data access raised with it");
		end

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
hdl/mmu_pkg.sv
hdl/tlb_lookup.sv
hdl/access_sequencer.sv
hdl/mmu_top.sv
verif/tb_clk_gen.sv
verif/mmu_properties.sv
verif/mmu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mmu_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
